/* common/starkPkg.sv */
package starkPkg;

	// ==================================================
	// Instruction word layout
	// ==================================================

	// Every instruction is one 32-bit word with the major opcode in the low bits
	localparam int instrWidth = 32;
	localparam int opWidth = 6;
	localparam int opHi = 5;
	localparam int opLo = 0;

	// Architectural register fields are five bits wide inside their group
	localparam int regFieldWidth = 5;

	// Destination and source register fields shared by most formats
	localparam int rdHi = 10;
	localparam int rdLo = 6;
	localparam int rs1Hi = 15;
	localparam int rs1Lo = 11;
	localparam int rs2Hi = 20;
	localparam int rs2Lo = 16;

	// MOV carries a sub-operation and explicit group selects for Rd and Rs1
	localparam int movSubHi = 28;
	localparam int movSubLo = 26;
	localparam int movRdGrpHi = 18;
	localparam int movRdGrpLo = 17;
	localparam int movRs1GrpHi = 20;
	localparam int movRs1GrpLo = 19;

	// MOVEMD places the requested operating mode here
	localparam int movModeHi = 22;
	localparam int movModeLo = 21;

	// Link register select of a branch, 0 and 7 mean no link
	localparam int linkHi = 8;
	localparam int linkLo = 6;

	// Sub-operations below this value use the group selects in the word
	localparam logic [2:0] movGrpSubLimit = 3'd4;

	// MOV sub-operation that changes the operating mode
	localparam logic [2:0] MOV_MOVEMD = 3'd1;

	// ==================================================
	// Opcodes and modes
	// ==================================================

	// Only the opcodes that carry register fields are listed
	typedef enum logic [opWidth-1:0] {
		OP_NOP = 6'd0,
		OP_ADD = 6'd4,
		OP_AND = 6'd8,
		OP_OR  = 6'd9,
		OP_XOR = 6'd10,
		OP_MOV = 6'd12,
		OP_FLT = 6'd16,
		OP_CSR = 6'd20,
		OP_B0  = 6'd24,
		OP_LDW = 6'd32,
		OP_STW = 6'd40
	} opcode_t;

	// Privilege level, higher values are more privileged
	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_HYPER   = 2'd2,
		MODE_MACHINE = 2'd3
	} operating_mode_t;

	// ==================================================
	// Register numbering
	// ==================================================

	// Seven-bit register number whose top two bits select a group of 32
	typedef logic [6:0] aregno_t;
	localparam int grpHi = 6;
	localparam int grpLo = 5;

	// Group 0 general, group 1 float and link, group 3 banked and machine only
	localparam logic [1:0] grpGen = 2'd0;
	localparam logic [1:0] grpFlt = 2'd1;
	localparam logic [1:0] grpBank = 2'd3;

	// First physical register of the banked copies
	localparam aregno_t bankBase = 7'd96;

endpackage

/* decode/decodeRd.sv */
module decodeRd
	import starkPkg::*;
#(
	parameter int bankSize = 8
)
(
	input  logic [instrWidth-1:0] instr,
	input  operating_mode_t       curMode,
	output aregno_t               rdPhysNext,
	output logic                  rdZeroNext,
	output logic                  rdExc,
	output logic                  isModeSet,
	output operating_mode_t       effMode
);

	opcode_t opc;
	logic [2:0] movSub;
	logic [regFieldWidth-1:0] rdField;
	logic [2:0] linkField;
	aregno_t rdArch;

	// Split out the fields the destination depends on
	assign opc = opcode_t'(instr[opHi:opLo]);
	assign movSub = instr[movSubHi:movSubLo];
	assign rdField = instr[rdHi:rdLo];
	assign linkField = instr[linkHi:linkLo];

	// ==================================================
	// Architectural destination select
	// ==================================================

	always_comb
	begin
		case (opc)
			// Low MOV sub-operations can reach any group through the word
			OP_MOV:
				if (movSub < movGrpSubLimit)
					rdArch = {instr[movRdGrpHi:movRdGrpLo], rdField};
				else
					rdArch = {grpGen, rdField};
			OP_FLT:
				rdArch = {grpFlt, rdField};
			OP_CSR, OP_ADD, OP_AND, OP_OR, OP_XOR, OP_LDW:
				rdArch = {grpGen, rdField};
			// Branch link writes one of the link registers 33..38
			OP_B0:
				if (linkField == 3'd0 || linkField == 3'd7)
					rdArch = '0;
				else
					rdArch = {grpFlt, 2'b00, linkField};
			// Stores, NOP and anything unknown write nothing
			default:
				rdArch = '0;
		endcase
	end

	// Register 0 as a target means the result is discarded
	assign rdZeroNext = (rdArch == '0);

	// MOVEMD maps its own destination under the mode it switches to
	assign isModeSet = (opc == OP_MOV) && (movSub == MOV_MOVEMD);
	assign effMode = isModeSet ? operating_mode_t'(instr[movModeHi:movModeLo]) : curMode;

	regMap #(
		.bankSize(bankSize)
	) uRdMap (
		.mode(effMode),
		.aReg(rdArch),
		.pReg(rdPhysNext),
		.exc(rdExc)
	);

endmodule

/* decode/decodeRs.sv */
module decodeRs
	import starkPkg::*;
#(
	parameter int bankSize = 8
)
(
	input  logic [instrWidth-1:0] instr,
	input  operating_mode_t       curMode,
	output aregno_t               rs1PhysNext,
	output aregno_t               rs2PhysNext,
	output logic                  rsExc
);

	opcode_t opc;
	logic [regFieldWidth-1:0] rs1Field;
	logic [regFieldWidth-1:0] rs2Field;
	aregno_t rs1Arch;
	aregno_t rs2Arch;
	logic rs1Exc;
	logic rs2Exc;

	assign opc = opcode_t'(instr[opHi:opLo]);
	assign rs1Field = instr[rs1Hi:rs1Lo];
	assign rs2Field = instr[rs2Hi:rs2Lo];

	// ==================================================
	// Source register selects
	// ==================================================

	// First source, also the base register of loads and stores
	always_comb
	begin
		case (opc)
			OP_ADD, OP_AND, OP_OR, OP_XOR, OP_LDW, OP_STW, OP_B0:
				rs1Arch = {grpGen, rs1Field};
			OP_FLT:
				rs1Arch = {grpFlt, rs1Field};
			OP_MOV:
				if (instr[movSubHi:movSubLo] < movGrpSubLimit)
					rs1Arch = {instr[movRs1GrpHi:movRs1GrpLo], rs1Field};
				else
					rs1Arch = {grpGen, rs1Field};
			default:
				rs1Arch = '0;
		endcase
	end

	// Second source, the store data for a store
	always_comb
	begin
		case (opc)
			OP_ADD, OP_AND, OP_OR, OP_XOR, OP_STW:
				rs2Arch = {grpGen, rs2Field};
			OP_FLT:
				rs2Arch = {grpFlt, rs2Field};
			default:
				rs2Arch = '0;
		endcase
	end

	// Sources are always read under the mode in force before this instruction
	regMap #(
		.bankSize(bankSize)
	) uRs1Map (
		.mode(curMode),
		.aReg(rs1Arch),
		.pReg(rs1PhysNext),
		.exc(rs1Exc)
	);

	regMap #(
		.bankSize(bankSize)
	) uRs2Map (
		.mode(curMode),
		.aReg(rs2Arch),
		.pReg(rs2PhysNext),
		.exc(rs2Exc)
	);

	// Either source touching a forbidden register faults the instruction
	assign rsExc = rs1Exc | rs2Exc;

endmodule

/* flist.f */
common/starkPkg.sv
hdl/regMap.sv
decode/decodeRd.sv
decode/decodeRs.sv
hdl/decodeCtrl.sv
hdl/starkDecodeTop.sv
sim/starkDecode_asserts.sv
sim/tbStarkDecode.sv

/* hdl/decodeCtrl.sv */
module decodeCtrl
	import starkPkg::*;
(
	input  logic            clk,
	input  logic            rstN,
	input  logic            instrValid,
	input  aregno_t         rdPhysNext,
	input  logic            rdZeroNext,
	input  logic            rdExc,
	input  aregno_t         rs1PhysNext,
	input  aregno_t         rs2PhysNext,
	input  logic            rsExc,
	input  logic            isModeSet,
	input  operating_mode_t effMode,
	output operating_mode_t curMode,
	output logic            decValid,
	output aregno_t         rdPhys,
	output logic            rdZero,
	output aregno_t         rs1Phys,
	output aregno_t         rs2Phys,
	output logic            decExc
);

	logic anyExc;
	logic modeWrite;

	// One fault flag for the whole instruction
	assign anyExc = rdExc | rsExc;

	// A faulting MOVEMD must not change the privilege level
	assign modeWrite = instrValid & isModeSet & ~anyExc;

	// ==================================================
	// Operating mode
	// ==================================================

	// Out of reset the core runs in user mode
	// The new mode applies to the instruction after the MOVEMD
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			curMode <= MODE_USER;
		else if (modeWrite)
			curMode <= effMode;
	end

	// ==================================================
	// Output stage
	// ==================================================

	// Valid follows the input strobe by exactly one clock
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			decValid <= 1'b0;
		else
			decValid <= instrValid;
	end

	// Results are captured only on a strobe and held otherwise
	// so the consumer can read them late if it wants
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdPhys <= '0;
			rdZero <= 1'b0;
			rs1Phys <= '0;
			rs2Phys <= '0;
			decExc <= 1'b0;
		end
		else if (instrValid)
		begin
			rdPhys <= rdPhysNext;
			rdZero <= rdZeroNext;
			rs1Phys <= rs1PhysNext;
			rs2Phys <= rs2PhysNext;
			decExc <= anyExc;
		end
		// Drop the fault with the strobe so it never shows without a result
		else
			decExc <= 1'b0;
	end

endmodule

/* hdl/regMap.sv */
module regMap
	import starkPkg::*;
#(
	// Number of top general registers banked per mode, legal range 1 to 8
	parameter int bankSize = 8
)
(
	input  operating_mode_t mode,
	input  aregno_t         aReg,
	output aregno_t         pReg,
	output logic            exc
);

	// First general register that has a per-mode copy
	localparam aregno_t bankFirst = aregno_t'(32 - bankSize);
	localparam aregno_t bankLen = aregno_t'(bankSize);

	logic isBanked;
	aregno_t modeBase;
	aregno_t bankOffset;

	// Only the top bankSize registers of group 0 are banked
	assign isBanked = (aReg[grpHi:grpLo] == grpGen) && (aReg >= bankFirst);

	// Each mode owns a block of bankSize registers above bankBase
	assign modeBase = bankBase + aregno_t'(mode) * bankLen;

	// Position of the register inside its bank
	assign bankOffset = aReg - bankFirst;

	// Registers outside the banked window keep their number
	assign pReg = isBanked ? modeBase + bankOffset : aReg;

	// Naming group 3 directly is a machine-mode privilege
	// An access from any lower mode traps
	assign exc = (aReg[grpHi:grpLo] == grpBank) && (mode != MODE_MACHINE);

endmodule

/* hdl/starkDecodeTop.sv */
module starkDecodeTop
	import starkPkg::*;
#(
	// Banked general registers per mode, shared by every mapper
	parameter int bankSize = 8
)
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  instrValid,
	input  logic [instrWidth-1:0] instr,
	output logic                  decValid,
	output aregno_t               rdPhys,
	output logic                  rdZero,
	output aregno_t               rs1Phys,
	output aregno_t               rs2Phys,
	output logic                  decExc,
	output operating_mode_t       mode
);

	// Combinational decode results heading into the output stage
	aregno_t rdPhysNext;
	logic rdZeroNext;
	logic rdExc;
	logic isModeSet;
	operating_mode_t effMode;
	aregno_t rs1PhysNext;
	aregno_t rs2PhysNext;
	logic rsExc;

	// ==================================================
	// Datapath
	// ==================================================

	// Both decoders see the mode register directly
	decodeRd #(
		.bankSize(bankSize)
	) uDecodeRd (
		.instr(instr),
		.curMode(mode),
		.rdPhysNext(rdPhysNext),
		.rdZeroNext(rdZeroNext),
		.rdExc(rdExc),
		.isModeSet(isModeSet),
		.effMode(effMode)
	);

	decodeRs #(
		.bankSize(bankSize)
	) uDecodeRs (
		.instr(instr),
		.curMode(mode),
		.rs1PhysNext(rs1PhysNext),
		.rs2PhysNext(rs2PhysNext),
		.rsExc(rsExc)
	);

	// ==================================================
	// Control
	// ==================================================

	decodeCtrl uDecodeCtrl (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.rdPhysNext(rdPhysNext),
		.rdZeroNext(rdZeroNext),
		.rdExc(rdExc),
		.rs1PhysNext(rs1PhysNext),
		.rs2PhysNext(rs2PhysNext),
		.rsExc(rsExc),
		.isModeSet(isModeSet),
		.effMode(effMode),
		.curMode(mode),
		.decValid(decValid),
		.rdPhys(rdPhys),
		.rdZero(rdZero),
		.rs1Phys(rs1Phys),
		.rs2Phys(rs2Phys),
		.decExc(decExc)
	);

endmodule

/* sim/starkDecode_asserts.sv */
module starkDecodeAsserts
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic decValid,
	input logic decExc
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench at the end of the run
	int assertFails = 0;

	// ==================================================
	// Output stage protocol
	// ==================================================

	// Two valid cycles in a row need two strobes in a row one cycle earlier
	validPairs: assert property (@(posedge clk) disable iff (!rstN)
		(decValid && $past(decValid)) |-> ($past(instrValid) && $past(instrValid, 2)))
	else
	begin
		$error("decValid held for two cycles without two strobes");
		assertFails++;
	end

	// A fault is only reported alongside a result
	excWithValid: assert property (@(posedge clk) disable iff (!rstN) decExc |-> decValid)
	else
	begin
		$error("decExc high while decValid low");
		assertFails++;
	end

	quietInReset: assert property (@(posedge clk) !rstN |-> (!decValid && !decExc))
	else
	begin
		$error("decValid or decExc high during reset");
		assertFails++;
	end

endmodule

/* sim/tbStarkDecode.sv */
module tbStarkDecode
	import starkPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int bankSize = 8;
	localparam int waitLimit = 20;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [31:0] instr;
	logic decValid;
	aregno_t rdPhys;
	logic rdZero;
	aregno_t rs1Phys;
	aregno_t rs2Phys;
	logic decExc;
	operating_mode_t mode;

	integer seed = 58;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int testErrStart = 0;

	// Mode as the reference model sees it after the last predicted instruction
	logic [1:0] modelMode;

	// Words of the next burst, filled by each test
	logic [31:0] burstWords[$];

	starkDecodeTop #(
		.bankSize(bankSize)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.decValid(decValid),
		.rdPhys(rdPhys),
		.rdZero(rdZero),
		.rs1Phys(rs1Phys),
		.rs2Phys(rs2Phys),
		.decExc(decExc),
		.mode(mode)
	);

	bind starkDecodeTop starkDecodeAsserts uDecodeAsserts (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.decValid(decValid),
		.decExc(decExc)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==================================================
	// Reference model
	// ==================================================

	// The top bankSize registers of group 0 get one copy per mode above 96
	function automatic logic [6:0] mapReg(input logic [6:0] a, input logic [1:0] m);
		int first;
		first = 32 - bankSize;
		if (a < 32 && a >= first)
			return 7'(96 + m * bankSize + a - first);
		return a;
	endfunction

	// Result layout is {mode, exc, rs2, rs1, zero, rd} where mode is the one after this word
	function automatic logic [24:0] predictResult(input logic [31:0] w, input logic [1:0] m);
		logic [5:0] op;
		logic [2:0] sub;
		logic [2:0] lnk;
		logic [6:0] rdA;
		logic [6:0] rs1A;
		logic [6:0] rs2A;
		logic [1:0] rdMode;
		logic [1:0] nextMode;
		logic movemd;
		logic exc;
		op = w[5:0];
		sub = w[28:26];
		lnk = w[8:6];
		rdA = 7'd0;
		rs1A = 7'd0;
		rs2A = 7'd0;
		case (op)
			OP_MOV:
			begin
				rdA = (sub < 3'd4) ? {w[18:17], w[10:6]} : {2'd0, w[10:6]};
				rs1A = (sub < 3'd4) ? {w[20:19], w[15:11]} : {2'd0, w[15:11]};
			end
			OP_FLT:
			begin
				rdA = {2'd1, w[10:6]};
				rs1A = {2'd1, w[15:11]};
				rs2A = {2'd1, w[20:16]};
			end
			OP_ADD, OP_AND, OP_OR, OP_XOR:
			begin
				rdA = {2'd0, w[10:6]};
				rs1A = {2'd0, w[15:11]};
				rs2A = {2'd0, w[20:16]};
			end
			OP_CSR:
				rdA = {2'd0, w[10:6]};
			OP_LDW:
			begin
				rdA = {2'd0, w[10:6]};
				rs1A = {2'd0, w[15:11]};
			end
			OP_STW:
			begin
				rs1A = {2'd0, w[15:11]};
				rs2A = {2'd0, w[20:16]};
			end
			// Link values 1..6 name registers 33..38
			OP_B0:
			begin
				rs1A = {2'd0, w[15:11]};
				rdA = (lnk == 3'd0 || lnk == 3'd7) ? 7'd0 : 7'd32 + lnk;
			end
			default:
				rdA = 7'd0;
		endcase
		movemd = (op == OP_MOV) && (sub == 3'd1);
		rdMode = movemd ? w[22:21] : m;
		exc = (rdA[6:5] == 2'd3 && rdMode != 2'd3) || (rs1A[6:5] == 2'd3 && m != 2'd3)
			|| (rs2A[6:5] == 2'd3 && m != 2'd3);
		nextMode = (movemd && !exc) ? w[22:21] : m;
		return {nextMode, exc, mapReg(rs2A, m), mapReg(rs1A, m), rdA == 7'd0,
			mapReg(rdA, rdMode)};
	endfunction

	// ==================================================
	// Stimulus and checking helpers
	// ==================================================

	function automatic logic [31:0] buildWord(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {11'd0, rs2, rs1, rd, op};
	endfunction

	function automatic logic [31:0] buildMov(input logic [2:0] sub, input logic [1:0] rdGrp,
		input logic [1:0] rs1Grp, input logic [1:0] newMode, input logic [4:0] rd,
		input logic [4:0] rs1);
		logic [31:0] w;
		w = buildWord(OP_MOV, rd, rs1, 5'd0);
		w[28:26] = sub;
		w[18:17] = rdGrp;
		w[20:19] = rs1Grp;
		w[22:21] = newMode;
		return w;
	endfunction

	function automatic logic [5:0] opByIndex(input int i);
		case (i)
			0: return OP_NOP;
			1: return OP_ADD;
			2: return OP_AND;
			3: return OP_OR;
			4: return OP_XOR;
			5: return OP_MOV;
			6: return OP_FLT;
			7: return OP_CSR;
			8: return OP_B0;
			9: return OP_LDW;
			default: return OP_STW;
		endcase
	endfunction

	task automatic reportMismatch(input string name, input int expVal, input int actVal);
		errors++;
		$display("CHECK FAILED at %0d ns: %s expected %0d, got %0d",
			$time, name, expVal, actVal);
	endtask

	task automatic checkResult(input logic [24:0] e);
		checks++;
		if (rdPhys !== e[6:0])
			reportMismatch("rdPhys", e[6:0], rdPhys);
		if (rdZero !== e[7])
			reportMismatch("rdZero", e[7], rdZero);
		if (rs1Phys !== e[14:8])
			reportMismatch("rs1Phys", e[14:8], rs1Phys);
		if (rs2Phys !== e[21:15])
			reportMismatch("rs2Phys", e[21:15], rs2Phys);
		if (decExc !== e[22])
			reportMismatch("decExc", e[22], decExc);
		if (mode !== e[24:23])
			reportMismatch("mode", e[24:23], mode);
	endtask

	// Outputs are sampled on the falling edge, half a cycle clear of any update
	// The count tells how many extra falling edges passed before decValid showed up
	task automatic waitForValid(output bit ok, output int n);
		n = 0;
		@(negedge clk);
		while (decValid !== 1'b1 && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		ok = (decValid === 1'b1);
	endtask

	// Sends the queued words on consecutive cycles and checks each result in order
	task automatic runBurst();
		logic [24:0] expected[$];
		bit ok;
		int lag;
		foreach (burstWords[i])
		begin
			expected.push_back(predictResult(burstWords[i], modelMode));
			modelMode = expected[i][24:23];
		end
		fork
			begin
				foreach (burstWords[i])
				begin
					@(posedge clk);
					instrValid <= 1'b1;
					instr <= burstWords[i];
				end
				@(posedge clk);
				instrValid <= 1'b0;
			end
			begin
				// Start on the edge that launches the first strobe
				@(posedge clk);
				foreach (expected[i])
				begin
					waitForValid(ok, lag);
					if (!ok)
					begin
						errors++;
						$display("ERROR: no decode result within %0d cycles at %0d ns",
							waitLimit, $time);
					end
					else
					begin
						// The first result trails its strobe by one cycle and the rest follow back to back
						if (lag != ((i == 0) ? 1 : 0))
						begin
							errors++;
							$display("ERROR: burst result %0d came %0d cycles off its slot at %0d ns",
								i, lag, $time);
						end
						checkResult(expected[i]);
					end
				end
				// Valid drops once the strobes stop
				@(negedge clk);
				if (decValid !== 1'b0)
					reportMismatch("decValid", 0, decValid);
			end
		join
		burstWords = {};
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		$display("[done] %s with %0d errors", name, errors - testErrStart);
		testErrStart = errors;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic aluLoadStoreDecode();
		burstWords.push_back(buildWord(OP_ADD, 5'd5, 5'd6, 5'd7));
		// Banked registers in user mode land in the first bank
		burstWords.push_back(buildWord(OP_ADD, 5'd24, 5'd31, 5'd25));
		burstWords.push_back(buildWord(OP_LDW, 5'd3, 5'd9, 5'd13));
		burstWords.push_back(buildWord(OP_STW, 5'd12, 5'd10, 5'd11));
		runBurst();
		finishTest("ALU and load/store decode");
	endtask

	task automatic zeroAndLinkDecode();
		for (int l = 0; l < 8; l++)
			burstWords.push_back(buildWord(OP_B0, 5'(l), 5'd4, 5'd0));
		burstWords.push_back(buildWord(OP_NOP, 5'd9, 5'd9, 5'd9));
		runBurst();
		finishTest("zero destination and branch link");
	endtask

	task automatic bankedModeMapping();
		// Each MOVEMD is followed by an ADD that touches the banked window
		for (int m = 1; m < 4; m++)
		begin
			burstWords.push_back(buildMov(MOV_MOVEMD, 2'd0, 2'd0, 2'(m), 5'd28, 5'd0));
			burstWords.push_back(buildWord(OP_ADD, 5'(23 + m), 5'd31, 5'(26 + m)));
		end
		runBurst();
		finishTest("banked mapping across modes");
	endtask

	task automatic privilegeTrap();
		burstWords.push_back(buildMov(MOV_MOVEMD, 2'd0, 2'd0, 2'd0, 5'd1, 5'd2));
		burstWords.push_back(buildMov(3'd0, 2'd3, 2'd0, 2'd0, 5'd2, 5'd3));
		burstWords.push_back(buildMov(3'd2, 2'd0, 2'd3, 2'd0, 5'd2, 5'd3));
		// Trapping MOVEMD must leave the mode in user
		burstWords.push_back(buildMov(MOV_MOVEMD, 2'd3, 2'd0, 2'd1, 5'd4, 5'd0));
		burstWords.push_back(buildMov(MOV_MOVEMD, 2'd0, 2'd0, 2'd3, 5'd4, 5'd0));
		burstWords.push_back(buildMov(3'd0, 2'd3, 2'd3, 2'd0, 5'd2, 5'd3));
		runBurst();
		finishTest("privilege exception");
	endtask

	task automatic randomStream();
		int idx;
		logic [31:0] w;
		for (int i = 0; i < 40; i++)
		begin
			w = $random(seed);
			idx = $unsigned($random(seed)) % 11;
			w[5:0] = opByIndex(idx);
			burstWords.push_back(w);
		end
		runBurst();
		finishTest("back-to-back random stream");
	endtask

	initial
	begin
		rstN = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		modelMode = 2'd0;
		#5;
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		aluLoadStoreDecode();
		zeroAndLinkDecode();
		bankedModeMapping();
		privilegeTrap();
		randomStream();
		errors = errors + i_dut.uDecodeAsserts.assertFails;
		$display("Summary: %0d tests, %0d results checked, %0d errors", testsRun, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
